/* verilog.f */
common/island_pkg.sv
periph/soc_ctrl_regs.sv
periph/periph_subsys.sv
mem/sram_bank.sv
xbar/island_xbar.sv
src/island_top.sv
test/tb_island_assertions.sv
test/tb_island.sv

/* Makefile */
# Verilator build and run of the safety-island testbench

SRCS := $(wildcard common/*.sv xbar/*.sv mem/*.sv periph/*.sv src/*.sv test/*.sv)

.PHONY: all run clean

all: run

obj_dir/Vtb_island: verilog.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module tb_island -f verilog.f

run: obj_dir/Vtb_island
	@out="$$(./obj_dir/Vtb_island)"; echo "$$out"; echo "$$out" | grep -qx "test passed"

clean:
	rm -rf obj_dir

/* test/tb_island.sv */
/*
 * Testbench for the safety-island interconnect.
 * Directed checks of reset, error and control accesses, then random
 * traffic from both masters checked against a reference model.
 */
`timescale 1ns/1ps

module tb_island;

  localparam int unsigned CLK_PERIOD = 20;
  localparam int unsigned SETTLE     = 5;
  localparam int          WIN_WORDS  = 16;
  localparam int unsigned NUM_CYCLES = 3000;
  localparam int unsigned NUM_TXNS   = NUM_CYCLES + WIN_WORDS + 16;
  localparam int unsigned TIMEOUT_NS = (NUM_TXNS * 20 + 1000) * CLK_PERIOD;

  typedef enum logic [1:0] {R_INSTR, R_DATA, R_CTRL, R_ERR} region_e;

  logic                                          clk;
  logic                                          rst_n;
  logic [island_pkg::NUM_MASTERS-1:0]            mst_valid;
  island_pkg::bus_req_t [island_pkg::NUM_MASTERS-1:0] mst_req;
  logic [island_pkg::NUM_MASTERS-1:0]            mst_ready;
  logic [island_pkg::NUM_MASTERS-1:0]            mst_rsp_valid;
  island_pkg::bus_rsp_t [island_pkg::NUM_MASTERS-1:0] mst_rsp;
  logic                                          fetch_enable;
  logic [island_pkg::ADDR_WIDTH-1:0]             boot_addr;

  // Reference model state
  logic [31:0]          instr_mem [WIN_WORDS];
  logic [31:0]          data_mem [WIN_WORDS];
  logic                 fe_model;
  logic [31:0]          boot_model;
  logic                 rr_ptr [4];
  island_pkg::bus_rsp_t exp_rsp [island_pkg::NUM_MASTERS];
  logic [31:0]          rng_state;
  int                   err_rsp, err_ctrl, err_hs, err_other;
  int                   n_contested, n_parallel;

  island_top u_dut (
    .clk_i           (clk),
    .rst_ni          (rst_n),
    .mst_valid_i     (mst_valid),
    .mst_req_i       (mst_req),
    .mst_ready_o     (mst_ready),
    .mst_rsp_valid_o (mst_rsp_valid),
    .mst_rsp_o       (mst_rsp),
    .fetch_enable_o  (fetch_enable),
    .boot_addr_o     (boot_addr)
  );

  initial begin : proc_clk
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // --------------------
  // Helpers
  // --------------------
  function automatic logic [31:0] rand32();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  function automatic region_e region_of(input logic [31:0] addr);
    region_e r;
    r = R_ERR;
    if (addr >= island_pkg::INSTR_BASE && addr < island_pkg::DATA_BASE) begin
      r = R_INSTR;
    end else if (addr >= island_pkg::DATA_BASE &&
                 addr < island_pkg::DATA_BASE + island_pkg::BANK_NUM_BYTES) begin
      r = R_DATA;
    end else if (addr >= island_pkg::PERIPH_BASE &&
                 addr < island_pkg::PERIPH_BASE + island_pkg::SOC_CTRL_SIZE) begin
      r = R_CTRL;
    end
    return r;
  endfunction

  // Error accesses share the peripheral port
  function automatic region_e port_of(input logic [31:0] addr);
    region_e r;
    r = region_of(addr);
    if (r == R_ERR) begin
      r = R_CTRL;
    end
    return r;
  endfunction

  function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] wdata,
                                              input logic [3:0] be);
    logic [31:0] res;
    res = old;
    for (int b = 0; b < 4; b++) begin
      if (be[b]) begin
        res[8*b +: 8] = wdata[8*b +: 8];
      end
    end
    return res;
  endfunction

  function automatic logic [31:0] fill_word(input logic [31:0] addr);
    return addr ^ {addr[15:0], addr[31:16]} ^ 32'h5A5A_C3C3;
  endfunction

  function automatic island_pkg::bus_req_t make_req(input logic we, input logic [3:0] be,
                                                    input logic [31:0] addr,
                                                    input logic [31:0] wdata);
    island_pkg::bus_req_t req;
    req.we    = we;
    req.be    = be;
    req.addr  = addr;
    req.wdata = wdata;
    return req;
  endfunction

  // Banks weighted heavier and offsets kept inside the initialized window
  function automatic island_pkg::bus_req_t random_req();
    logic [31:0] pick;
    logic [31:0] ctl;
    logic [31:0] addr;
    pick = rand32();
    ctl  = rand32();
    if (pick[3:0] < 4'd6) begin
      addr = island_pkg::INSTR_BASE + {26'd0, pick[7:4], 2'b00};
    end else if (pick[3:0] < 4'd12) begin
      addr = island_pkg::DATA_BASE + {26'd0, pick[7:4], 2'b00};
    end else if (pick[3:0] < 4'd14) begin
      addr = island_pkg::PERIPH_BASE + {28'd0, pick[5:4], 2'b00};
    end else if (pick[3:0] == 4'd14) begin
      addr = island_pkg::PERIPH_BASE + island_pkg::SOC_CTRL_SIZE + {20'd0, pick[13:4], 2'b00};
    end else if (pick[16]) begin
      addr = island_pkg::DATA_BASE + island_pkg::BANK_NUM_BYTES + {20'd0, pick[13:4], 2'b00};
    end else begin
      addr = {1'b1, pick[30:4], 4'b0000};
    end
    return make_req(ctl[4], ctl[3:0], addr, rand32());
  endfunction

  // Applies one accepted request to the model and returns its response
  function automatic island_pkg::bus_rsp_t apply_model(input island_pkg::bus_req_t req);
    island_pkg::bus_rsp_t rsp;
    int                   idx;
    logic [11:0]          off;
    rsp.rdata = '0;
    rsp.err   = 1'b0;
    idx       = int'(req.addr[11:2]);
    off       = {req.addr[11:2], 2'b00};
    case (region_of(req.addr))
      R_INSTR: begin
        if (idx < WIN_WORDS && req.we) begin
          instr_mem[idx] = merge_bytes(instr_mem[idx], req.wdata, req.be);
        end else if (idx < WIN_WORDS) begin
          rsp.rdata = instr_mem[idx];
        end
      end
      R_DATA: begin
        if (idx < WIN_WORDS && req.we) begin
          data_mem[idx] = merge_bytes(data_mem[idx], req.wdata, req.be);
        end else if (idx < WIN_WORDS) begin
          rsp.rdata = data_mem[idx];
        end
      end
      R_CTRL: begin
        if (req.we) begin
          if (off == island_pkg::SOC_CTRL_FETCHEN_OFFSET && req.be[0]) fe_model = req.wdata[0];
          if (off == island_pkg::SOC_CTRL_BOOTADDR_OFFSET) begin
            boot_model = merge_bytes(boot_model, req.wdata, req.be);
          end
        end else if (off == island_pkg::SOC_CTRL_FETCHEN_OFFSET) begin
          rsp.rdata = {31'd0, fe_model};
        end else if (off == island_pkg::SOC_CTRL_BOOTADDR_OFFSET) begin
          rsp.rdata = boot_model;
        end
      end
      default: begin
        rsp.rdata = island_pkg::ERROR_RDATA;
        rsp.err   = 1'b1;
      end
    endcase
    return rsp;
  endfunction

  // Contested port goes to its pointer, which then moves to the other master
  function automatic logic [1:0] predict_grant();
    logic [1:0] gnt;
    region_e    p0;
    region_e    p1;
    p0 = port_of(mst_req[0].addr);
    p1 = port_of(mst_req[1].addr);
    if (mst_valid[0] && mst_valid[1] && p0 == p1) begin
      gnt             = '0;
      gnt[rr_ptr[p0]] = 1'b1;
      rr_ptr[p0]      = ~rr_ptr[p0];
      n_contested++;
    end else begin
      gnt = mst_valid;
    end
    return gnt;
  endfunction

  // --------------------
  // Compare tasks
  // --------------------
  task automatic check_rsp(input int m, input island_pkg::bus_rsp_t got,
                           input island_pkg::bus_rsp_t exp);
    if (got !== exp) begin
      err_rsp++;
      $display("Fail mst_rsp_o[%0d]: rdata %h err %h, expected rdata %h err %h",
               m, got.rdata, got.err, exp.rdata, exp.err);
    end
  endtask

  task automatic check_ctrl(input logic got_fe, input logic [31:0] got_ba);
    if (got_fe !== fe_model) begin
      err_ctrl++;
      $display("Fail fetch_enable_o: got %h expected %h", got_fe, fe_model);
    end
    if (got_ba !== boot_model) begin
      err_ctrl++;
      $display("Fail boot_addr_o: got %h expected %h", got_ba, boot_model);
    end
  endtask

  task automatic check_handshake(input string name, input logic [1:0] got, input logic [1:0] exp);
    if (got !== exp) begin
      err_hs++;
      $display("Fail %s: got %h expected %h", name, got, exp);
    end
  endtask

  // One bus cycle, entered at the falling edge right after driving the inputs
  task automatic bus_cycle(output logic [1:0] accepted);
    logic [1:0] pend;
    #(SETTLE);
    check_handshake("mst_ready_o", mst_ready, predict_grant());
    accepted = mst_valid & mst_ready;
    pend     = '0;
    for (int m = 0; m < island_pkg::NUM_MASTERS; m++) begin
      if (accepted[m]) begin
        exp_rsp[m] = apply_model(mst_req[m]);
        pend[m]    = 1'b1;
      end
    end
    if (accepted == 2'b11) n_parallel++;
    @(negedge clk);
    check_handshake("mst_rsp_valid_o", mst_rsp_valid, pend);
    for (int m = 0; m < island_pkg::NUM_MASTERS; m++) begin
      if (pend[m]) check_rsp(m, mst_rsp[m], exp_rsp[m]);
    end
    check_ctrl(fetch_enable, boot_addr);
  endtask

  task automatic single_access(input int m, input island_pkg::bus_req_t req);
    logic [1:0] acc;
    mst_valid    = '0;
    mst_valid[m] = 1'b1;
    mst_req[m]   = req;
    bus_cycle(acc);
    if (!acc[m]) begin
      err_other++;
      $display("Request on master %0d was not accepted on an idle bus", m);
    end
    mst_valid = '0;
  endtask

  // --------------------
  // Stimulus
  // --------------------
  initial begin : proc_main
    logic [1:0]  acc;
    logic [1:0]  held;
    logic [31:0] addr;
    logic [31:0] r;
    rng_state  = 32'hd378;
    {err_rsp, err_ctrl, err_hs, err_other} = '0;
    n_contested = 0;
    n_parallel  = 0;
    fe_model    = 1'b0;
    boot_model  = island_pkg::BOOT_ADDR_RESET;
    rr_ptr      = '{default: 1'b0};
    mst_valid   = '0;
    mst_req     = '0;
    rst_n       = 1'b0;
    repeat (10) @(negedge clk);
    rst_n = 1'b1;
    check_handshake("mst_rsp_valid_o", mst_rsp_valid, '0);
    check_ctrl(fetch_enable, boot_addr);
    single_access(0, make_req(1'b0, 4'hf, island_pkg::PERIPH_BASE, '0));
    single_access(1, make_req(1'b0, 4'hf, island_pkg::PERIPH_BASE + 32'd4, '0));

    // Fill both windows at once with one master per bank
    for (int i = 0; i < WIN_WORDS; i++) begin
      mst_valid  = '1;
      addr       = island_pkg::INSTR_BASE + 32'(i * 4);
      mst_req[0] = make_req(1'b1, 4'hf, addr, fill_word(addr));
      addr       = island_pkg::DATA_BASE + 32'(i * 4);
      mst_req[1] = make_req(1'b1, 4'hf, addr, fill_word(addr));
      bus_cycle(acc);
      if (acc != 2'b11) begin
        err_other++;
        $display("Requests to different banks were not accepted in the same cycle");
      end
    end
    mst_valid = '0;

    single_access(0, make_req(1'b0, 4'hf, island_pkg::PERIPH_BASE + 32'h1000, '0));
    single_access(1, make_req(1'b1, 4'h3, island_pkg::PERIPH_BASE + 32'h2ff0, 32'h1234_5678));
    single_access(0, make_req(1'b1, 4'hf, 32'h0000_0000, 32'hffff_ffff));
    single_access(1, make_req(1'b0, 4'hf, 32'hffff_fffc, '0));
    single_access(0, make_req(1'b1, 4'h1, island_pkg::PERIPH_BASE, 32'h0000_0001));
    single_access(1, make_req(1'b1, 4'hf, island_pkg::PERIPH_BASE + 32'd4, 32'h1000_0080));
    single_access(0, make_req(1'b0, 4'hf, island_pkg::PERIPH_BASE, '0));
    single_access(0, make_req(1'b0, 4'hf, island_pkg::PERIPH_BASE + 32'd4, '0));

    // Both masters on the same bank and the loser served one cycle later
    mst_valid  = 2'b11;
    mst_req[0] = make_req(1'b0, 4'hf, island_pkg::DATA_BASE, '0);
    mst_req[1] = make_req(1'b0, 4'hf, island_pkg::DATA_BASE + 32'd4, '0);
    bus_cycle(acc);
    if (acc != 2'b01 && acc != 2'b10) begin
      err_other++;
      $display("Contended requests were not granted to exactly one master");
    end
    mst_valid = mst_valid & ~acc;
    bus_cycle(acc);
    if (acc != mst_valid) begin
      err_other++;
      $display("The losing master was not served on the next cycle");
    end
    mst_valid = '0;

    // Random phase counts its own contested and parallel grants
    n_contested = 0;
    n_parallel  = 0;
    acc = '0;
    for (int unsigned c = 0; c < NUM_CYCLES; c++) begin
      held = mst_valid & ~acc;
      for (int m = 0; m < island_pkg::NUM_MASTERS; m++) begin
        if (!held[m]) begin
          r            = rand32();
          mst_valid[m] = (r[1:0] != 2'b00);
          mst_req[m]   = random_req();
        end
      end
      bus_cycle(acc);
    end
    mst_valid = '0;

    if (n_contested == 0 || n_parallel == 0) begin
      err_other++;
      $display("Random traffic never produced both contested and parallel grants");
    end
    $display("Errors: response %0d, control %0d, handshake %0d, other %0d",
             err_rsp, err_ctrl, err_hs, err_other);
    if (err_rsp + err_ctrl + err_hs + err_other == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

  initial begin : proc_watchdog
    #(TIMEOUT_NS);
    $display("Timeout: the run did not finish within %0d ns", TIMEOUT_NS);
    $display("test failed");
    $finish;
  end

endmodule

/* test/tb_island_assertions.sv */
/*
 * Concurrent checks on the master handshake of the crossbar.
 * Bound into island_xbar, so every crossbar instance carries them.
 */
`timescale 1ns/1ps

module tb_island_assertions (
  input logic                               clk_i,
  input logic                               rst_ni,
  input logic [island_pkg::NUM_MASTERS-1:0] valid_i,
  input logic [island_pkg::NUM_MASTERS-1:0] ready_i,
  input logic [island_pkg::NUM_MASTERS-1:0] rsp_valid_i
);

  // Response exactly one cycle after each acceptance, never otherwise
  a_rsp_latency : assert property (@(posedge clk_i) disable iff (!rst_ni)
    rsp_valid_i == $past(valid_i & ready_i))
    else $error("rsp_valid does not follow acceptance by one cycle");

  a_ready_needs_valid : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (ready_i & ~valid_i) == '0)
    else $error("ready is high on a master without valid");

  a_rsp_idle_after_reset : assert property (@(posedge clk_i)
    $rose(rst_ni) |-> rsp_valid_i == '0)
    else $error("rsp_valid is high in the cycle after reset release");

endmodule

bind island_xbar tb_island_assertions u_assertions (
  .clk_i       (clk_i),
  .rst_ni      (rst_ni),
  .valid_i     (mst_valid_i),
  .ready_i     (mst_ready_o),
  .rsp_valid_i (mst_rsp_valid_o)
);

/* src/island_top.sv */
/*
 * Top level of the safety-island interconnect.
 * Two masters reach the instruction bank, the data bank and the
 * peripheral subsystem through the crossbar.
 */
`timescale 1ns/1ps

module island_top (
  input  logic                                         clk_i,
  input  logic                                         rst_ni,
  input  logic [island_pkg::NUM_MASTERS-1:0]           mst_valid_i,
  input  island_pkg::bus_req_t [island_pkg::NUM_MASTERS-1:0] mst_req_i,
  output logic [island_pkg::NUM_MASTERS-1:0]           mst_ready_o,
  output logic [island_pkg::NUM_MASTERS-1:0]           mst_rsp_valid_o,
  output island_pkg::bus_rsp_t [island_pkg::NUM_MASTERS-1:0] mst_rsp_o,
  output logic                                         fetch_enable_o,
  output logic [island_pkg::ADDR_WIDTH-1:0]            boot_addr_o
);

  logic [island_pkg::TGT_PERIPH:island_pkg::TGT_INSTR]                 tgt_valid;
  island_pkg::bus_req_t [island_pkg::TGT_PERIPH:island_pkg::TGT_INSTR] tgt_req;
  island_pkg::bus_rsp_t [island_pkg::TGT_PERIPH:island_pkg::TGT_INSTR] tgt_rsp;

  island_xbar u_xbar (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .mst_valid_i     (mst_valid_i),
    .mst_req_i       (mst_req_i),
    .mst_ready_o     (mst_ready_o),
    .mst_rsp_valid_o (mst_rsp_valid_o),
    .mst_rsp_o       (mst_rsp_o),
    .tgt_valid_o     (tgt_valid),
    .tgt_req_o       (tgt_req),
    .tgt_rsp_i       (tgt_rsp)
  );

  // --------------------
  // Targets
  // --------------------
  sram_bank u_instr_bank (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req_valid_i (tgt_valid[island_pkg::TGT_INSTR]),
    .req_i       (tgt_req[island_pkg::TGT_INSTR]),
    .rsp_o       (tgt_rsp[island_pkg::TGT_INSTR])
  );

  sram_bank u_data_bank (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req_valid_i (tgt_valid[island_pkg::TGT_DATA]),
    .req_i       (tgt_req[island_pkg::TGT_DATA]),
    .rsp_o       (tgt_rsp[island_pkg::TGT_DATA])
  );

  periph_subsys u_periph (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .req_valid_i    (tgt_valid[island_pkg::TGT_PERIPH]),
    .req_i          (tgt_req[island_pkg::TGT_PERIPH]),
    .rsp_o          (tgt_rsp[island_pkg::TGT_PERIPH]),
    .fetch_enable_o (fetch_enable_o),
    .boot_addr_o    (boot_addr_o)
  );

endmodule

/* xbar/island_xbar.sv */
/*
 * Two-master crossbar of the safety island.
 * Routes each request to the instruction bank, the data bank or the
 * peripheral port, arbitrates per target with a round-robin pointer and
 * returns the target response to the owning master one cycle later.
 */
`timescale 1ns/1ps

module island_xbar (
  input  logic                                         clk_i,
  input  logic                                         rst_ni,
  input  logic [island_pkg::NUM_MASTERS-1:0]           mst_valid_i,
  input  island_pkg::bus_req_t [island_pkg::NUM_MASTERS-1:0] mst_req_i,
  output logic [island_pkg::NUM_MASTERS-1:0]           mst_ready_o,
  output logic [island_pkg::NUM_MASTERS-1:0]           mst_rsp_valid_o,
  output island_pkg::bus_rsp_t [island_pkg::NUM_MASTERS-1:0] mst_rsp_o,
  output logic [island_pkg::TGT_PERIPH:island_pkg::TGT_INSTR] tgt_valid_o,
  output island_pkg::bus_req_t [island_pkg::TGT_PERIPH:island_pkg::TGT_INSTR] tgt_req_o,
  input  island_pkg::bus_rsp_t [island_pkg::TGT_PERIPH:island_pkg::TGT_INSTR] tgt_rsp_i
);

  island_pkg::target_e [island_pkg::NUM_MASTERS-1:0] mst_port;
  island_pkg::target_e [island_pkg::NUM_MASTERS-1:0] pend_tgt_q;
  logic [island_pkg::NUM_MASTERS-1:0]                rsp_pend_q;

  logic [island_pkg::TGT_PERIPH:island_pkg::TGT_INSTR][island_pkg::NUM_MASTERS-1:0] gnt;
  island_pkg::mst_idx_t [island_pkg::TGT_PERIPH:island_pkg::TGT_INSTR] rr_q, rr_d;

  // Error addresses are answered by the peripheral subsystem
  always_comb begin : proc_decode
    for (int m = 0; m < island_pkg::NUM_MASTERS; m++) begin
      mst_port[m] = island_pkg::decode_target(mst_req_i[m].addr);
      if (mst_port[m] == island_pkg::TGT_ERROR) begin
        mst_port[m] = island_pkg::TGT_PERIPH;
      end
    end
  end

  // --------------------
  // Arbitration
  // --------------------
  always_comb begin : proc_arb
    int unsigned idx;
    int unsigned win;
    int unsigned n_req;
    gnt  = '0;
    rr_d = rr_q;
    for (int p = island_pkg::TGT_INSTR; p <= island_pkg::TGT_PERIPH; p++) begin
      n_req = 0;
      win   = 0;
      // Search starts at the pointer, first requester wins
      for (int k = 0; k < island_pkg::NUM_MASTERS; k++) begin
        idx = (int'(rr_q[p]) + k) % island_pkg::NUM_MASTERS;
        if (mst_valid_i[idx] && mst_port[idx] == island_pkg::target_e'(p)) begin
          if (n_req == 0) begin
            win = idx;
            gnt[p][idx] = 1'b1;
          end
          n_req++;
        end
      end
      if (n_req > 1) begin
        rr_d[p] = island_pkg::mst_idx_t'((win + 1) % island_pkg::NUM_MASTERS);
      end
    end
  end

  always_comb begin : proc_route
    mst_ready_o = '0;
    for (int p = island_pkg::TGT_INSTR; p <= island_pkg::TGT_PERIPH; p++) begin
      tgt_valid_o[p] = |gnt[p];
      tgt_req_o[p]   = mst_req_i[0];
      for (int m = 0; m < island_pkg::NUM_MASTERS; m++) begin
        if (gnt[p][m]) begin
          tgt_req_o[p]   = mst_req_i[m];
          mst_ready_o[m] = 1'b1;
        end
      end
    end
  end

  // --------------------
  // Response return
  // --------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin : proc_state
    if (!rst_ni) begin
      rr_q       <= '0;
      rsp_pend_q <= '0;
      for (int m = 0; m < island_pkg::NUM_MASTERS; m++) begin
        pend_tgt_q[m] <= island_pkg::TGT_PERIPH;
      end
    end else begin
      rr_q       <= rr_d;
      rsp_pend_q <= mst_ready_o;
      for (int m = 0; m < island_pkg::NUM_MASTERS; m++) begin
        if (mst_ready_o[m]) begin
          pend_tgt_q[m] <= mst_port[m];
        end
      end
    end
  end

  always_comb begin : proc_rsp
    for (int m = 0; m < island_pkg::NUM_MASTERS; m++) begin
      mst_rsp_o[m] = tgt_rsp_i[pend_tgt_q[m]];
    end
  end

  assign mst_rsp_valid_o = rsp_pend_q;

endmodule

/* mem/sram_bank.sv */
/*
 * Single-port word SRAM bank with byte enables.
 * Writes commit at the request edge, read data follows one cycle later.
 */
`timescale 1ns/1ps

module sram_bank (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 req_valid_i,
  input  island_pkg::bus_req_t req_i,
  output island_pkg::bus_rsp_t rsp_o
);

  logic [island_pkg::DATA_WIDTH-1:0]     mem [island_pkg::BANK_NUM_WORDS];
  logic [island_pkg::DATA_WIDTH-1:0]     rdata_q;
  logic [island_pkg::BANK_IDX_WIDTH-1:0] word_idx;

  // Upper address bits drop out, so the index wraps inside the bank
  assign word_idx = req_i.addr[island_pkg::BANK_IDX_WIDTH+1:2];

  always_ff @(posedge clk_i) begin : proc_write
    if (req_valid_i && req_i.we) begin
      for (int b = 0; b < island_pkg::BE_WIDTH; b++) begin
        if (req_i.be[b]) begin
          mem[word_idx][8*b +: 8] <= req_i.wdata[8*b +: 8];
        end
      end
    end
  end

  // Write responses carry zero data
  always_ff @(posedge clk_i or negedge rst_ni) begin : proc_read
    if (!rst_ni) begin
      rdata_q <= '0;
    end else if (req_valid_i) begin
      rdata_q <= req_i.we ? '0 : mem[word_idx];
    end
  end

  assign rsp_o = '{rdata: rdata_q, err: 1'b0};

endmodule

/* periph/periph_subsys.sv */
/*
 * Peripheral region of the safety island.
 * Splits requests between the SoC control registers and the error
 * responder and returns the matching response one cycle later.
 */
`timescale 1ns/1ps

module periph_subsys (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic                              req_valid_i,
  input  island_pkg::bus_req_t              req_i,
  output island_pkg::bus_rsp_t              rsp_o,
  output logic                              fetch_enable_o,
  output logic [island_pkg::ADDR_WIDTH-1:0] boot_addr_o
);

  island_pkg::periph_e  sel, sel_q;
  island_pkg::bus_rsp_t soc_ctrl_rsp;
  island_pkg::bus_rsp_t error_rsp;

  // Only the SoC control block is mapped, the rest falls to the error responder
  always_comb begin : proc_decode
    sel = island_pkg::PERIPH_ERROR;
    if (req_i.addr >= island_pkg::PERIPH_BASE &&
        req_i.addr < island_pkg::PERIPH_BASE + island_pkg::SOC_CTRL_SIZE) begin
      sel = island_pkg::PERIPH_SOC_CTRL;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : proc_sel
    if (!rst_ni) begin
      sel_q <= island_pkg::PERIPH_ERROR;
    end else if (req_valid_i) begin
      sel_q <= sel;
    end
  end

  soc_ctrl_regs u_soc_ctrl (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .req_valid_i    (req_valid_i && sel == island_pkg::PERIPH_SOC_CTRL),
    .req_i          (req_i),
    .rsp_o          (soc_ctrl_rsp),
    .fetch_enable_o (fetch_enable_o),
    .boot_addr_o    (boot_addr_o)
  );

  // Error responder, same answer for reads and writes
  assign error_rsp = '{rdata: island_pkg::ERROR_RDATA, err: 1'b1};

  assign rsp_o = (sel_q == island_pkg::PERIPH_SOC_CTRL) ? soc_ctrl_rsp : error_rsp;

endmodule

/* periph/soc_ctrl_regs.sv */
/*
 * SoC control registers: fetch enable at offset 0, boot address at 4.
 * Byte enables apply to writes, unmapped offsets read as zero.
 */
`timescale 1ns/1ps

module soc_ctrl_regs (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic                              req_valid_i,
  input  island_pkg::bus_req_t              req_i,
  output island_pkg::bus_rsp_t              rsp_o,
  output logic                              fetch_enable_o,
  output logic [island_pkg::ADDR_WIDTH-1:0] boot_addr_o
);

  logic [island_pkg::SOC_CTRL_OFF_WIDTH-1:0] offset;
  logic                                      sel_fetchen;
  logic                                      sel_bootaddr;
  logic                                      fetchen_q;
  logic [island_pkg::ADDR_WIDTH-1:0]         boot_addr_q;
  logic [island_pkg::DATA_WIDTH-1:0]         rdata_q;

  // Word aligned offset within the block
  assign offset       = {req_i.addr[island_pkg::SOC_CTRL_OFF_WIDTH-1:2], 2'b00};
  assign sel_fetchen  = (offset == island_pkg::SOC_CTRL_FETCHEN_OFFSET);
  assign sel_bootaddr = (offset == island_pkg::SOC_CTRL_BOOTADDR_OFFSET);

  always_ff @(posedge clk_i or negedge rst_ni) begin : proc_regs
    if (!rst_ni) begin
      fetchen_q   <= 1'b0;
      boot_addr_q <= island_pkg::BOOT_ADDR_RESET;
    end else if (req_valid_i && req_i.we) begin
      if (sel_fetchen && req_i.be[0]) begin
        fetchen_q <= req_i.wdata[0];
      end
      if (sel_bootaddr) begin
        for (int b = 0; b < island_pkg::BE_WIDTH; b++) begin
          if (req_i.be[b]) begin
            boot_addr_q[8*b +: 8] <= req_i.wdata[8*b +: 8];
          end
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin : proc_rdata
    if (req_valid_i) begin
      if (req_i.we) begin
        rdata_q <= '0;
      end else if (sel_fetchen) begin
        rdata_q <= island_pkg::DATA_WIDTH'(fetchen_q);
      end else if (sel_bootaddr) begin
        rdata_q <= boot_addr_q;
      end else begin
        rdata_q <= '0;
      end
    end
  end

  assign rsp_o          = '{rdata: rdata_q, err: 1'b0};
  assign fetch_enable_o = fetchen_q;
  assign boot_addr_o    = boot_addr_q;

endmodule

/* common/island_pkg.sv */
/*
 * Shared definitions for the safety-island interconnect.
 * Holds the address map, the request and response structs, the target
 * encodings and the address decode used by the crossbar and the testbench.
 */
package island_pkg;

  localparam int unsigned ADDR_WIDTH     = 32;
  localparam int unsigned DATA_WIDTH     = 32;
  localparam int unsigned BE_WIDTH       = 4;
  localparam int unsigned NUM_MASTERS    = 2;
  localparam int unsigned MST_IDX_WIDTH  = $clog2(NUM_MASTERS);

  // --------------------
  // Address map
  // --------------------
  localparam logic [ADDR_WIDTH-1:0] BASE_ADDR      = 32'h1000_0000;
  localparam logic [ADDR_WIDTH-1:0] ISLAND_SIZE    = 32'h0080_0000;
  localparam int unsigned           BANK_NUM_BYTES = 4096;
  localparam int unsigned           BANK_NUM_WORDS = BANK_NUM_BYTES / 4;
  localparam int unsigned           BANK_IDX_WIDTH = $clog2(BANK_NUM_WORDS);
  localparam logic [ADDR_WIDTH-1:0] INSTR_BASE     = BASE_ADDR;
  localparam logic [ADDR_WIDTH-1:0] DATA_BASE      = INSTR_BASE + BANK_NUM_BYTES;
  localparam logic [ADDR_WIDTH-1:0] PERIPH_BASE    = BASE_ADDR + 32'h0002_0000;
  localparam logic [ADDR_WIDTH-1:0] ISLAND_END     = BASE_ADDR + ISLAND_SIZE;

  // SoC control block, first region of the peripheral space
  localparam int unsigned           SOC_CTRL_SIZE      = 4096;
  localparam int unsigned           SOC_CTRL_OFF_WIDTH = $clog2(SOC_CTRL_SIZE);
  localparam logic [SOC_CTRL_OFF_WIDTH-1:0] SOC_CTRL_FETCHEN_OFFSET  = 0;
  localparam logic [SOC_CTRL_OFF_WIDTH-1:0] SOC_CTRL_BOOTADDR_OFFSET = 4;
  localparam logic [ADDR_WIDTH-1:0] BOOT_ADDR_RESET = INSTR_BASE;

  localparam logic [DATA_WIDTH-1:0] ERROR_RDATA = 32'hBADCAB1E;

  // --------------------
  // Bus types
  // --------------------
  typedef struct packed {
    logic                  we;
    logic [BE_WIDTH-1:0]   be;
    logic [ADDR_WIDTH-1:0] addr;
    logic [DATA_WIDTH-1:0] wdata;
  } bus_req_t;

  typedef struct packed {
    logic [DATA_WIDTH-1:0] rdata;
    logic                  err;
  } bus_rsp_t;

  typedef logic [MST_IDX_WIDTH-1:0] mst_idx_t;

  typedef enum logic [1:0] {TGT_ERROR, TGT_INSTR, TGT_DATA, TGT_PERIPH} target_e;
  typedef enum logic [0:0] {PERIPH_ERROR, PERIPH_SOC_CTRL} periph_e;

  // Anything outside the banks and the peripheral space is an error
  function automatic target_e decode_target(input logic [ADDR_WIDTH-1:0] addr);
    target_e tgt;
    tgt = TGT_ERROR;
    if (addr >= INSTR_BASE && addr < DATA_BASE) begin
      tgt = TGT_INSTR;
    end else if (addr >= DATA_BASE && addr < DATA_BASE + BANK_NUM_BYTES) begin
      tgt = TGT_DATA;
    end else if (addr >= PERIPH_BASE && addr < ISLAND_END) begin
      tgt = TGT_PERIPH;
    end
    return tgt;
  endfunction

endpackage
